//--- hdl/dec_config.svh
// widths, instruction field positions and encodings for the decode stage
// include wherever a macro below is needed, the guard makes repeats harmless
`ifndef DEC_CONFIG_SVH
`define DEC_CONFIG_SVH

`define DATA_WIDTH     32
`define ADDR_WIDTH     32
`define INSTR_WIDTH    32
`define REG_IDX_WIDTH  5
`define NUM_REGS       32
`define PC_STEP        4

// instruction fields
`define OPCODE_RANGE   6:0
`define RD_RANGE       11:7
`define FUNCT3_RANGE   14:12
`define RS1_RANGE      19:15
`define RS2_RANGE      24:20
`define FUNCT7_RANGE   31:25

// opcodes
`define LUI            7'b0110111
`define AUIPC          7'b0010111
`define JAL            7'b1101111
`define JALR           7'b1100111
`define BRANCH         7'b1100011
`define LOAD           7'b0000011
`define STORE          7'b0100011
`define ALU_IR         7'b0010011
`define ALU_RR         7'b0110011

// funct3 for alu ops
`define FUNCT3_ADD     3'b000
`define FUNCT3_SLL     3'b001
`define FUNCT3_SLT     3'b010
`define FUNCT3_SLTU    3'b011
`define FUNCT3_XOR     3'b100
`define FUNCT3_SRL     3'b101
`define FUNCT3_OR      3'b110
`define FUNCT3_AND     3'b111

// funct3 for branches
`define FUNCT3_BEQ     3'b000
`define FUNCT3_BNE     3'b001
`define FUNCT3_BLT     3'b100
`define FUNCT3_BGE     3'b101
`define FUNCT3_BLTU    3'b110
`define FUNCT3_BGEU    3'b111

// funct3 for loads and stores
`define FUNCT3_LSB     3'b000
`define FUNCT3_LSH     3'b001
`define FUNCT3_LBU     3'b100
`define FUNCT3_LHU     3'b101

`define FUNCT7_0         7'b0000000
`define FUNCT7_ARITH_SUB 7'b0100000
`define FUNCT7_MUL_DIV   7'b0000001

`endif

//--- hdl/dec_ex_reg.sv
// DEC to EX pipeline register
// single entry with valid/ready on both sides, flush drops the held item
`timescale 1ns/1ns

module dec_ex_reg (
	input                      cpu_clk,
	input                      cpu_rstn,
	input                      flush,
	input                      in_valid,
	output logic               in_ready,
	input  dec_pkg::ex_pkt_t   in_pkt,
	output logic               out_valid,
	input                      out_ready,
	output dec_pkg::ex_pkt_t   out_pkt
);

	logic accept;

	// free when empty or when the current item leaves this cycle
	assign in_ready = out_ready || !out_valid;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			out_valid <= 1'b0;
		end
		else if (flush)
		begin
			out_valid <= 1'b0; // also kills an item accepted this cycle
		end
		else if (in_ready)
		begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			out_pkt <= '0;
		end
		else if (flush)
		begin
			out_pkt <= '0;
		end
		else if (accept)
		begin
			out_pkt <= in_pkt;
		end
	end

	// a stalled item must reach EX unchanged
	a_hold_stable: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		(out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_pkt)));

endmodule

//--- hdl/dec_pkg.sv
// types shared across the decode stage
// modules refer to these by scoped name, widths come from the config header
`include "dec_config.svh"

package dec_pkg;

	typedef logic [`DATA_WIDTH-1:0]    data_t;
	typedef logic [`ADDR_WIDTH-1:0]    addr_t;
	typedef logic [`INSTR_WIDTH-1:0]   instr_t;
	typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

	typedef struct packed {
		instr_t instr;
		addr_t  pc;
	} fetch_pkt_t;

	// ex result forward, also the write-back port
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		data_t    data;
	} fwd_pkt_t;

	// one-hot alu op flags
	typedef struct packed {
		logic use_alu;
		logic alu_add;
		logic alu_sub;
		logic alu_com;
		logic alu_ucom;
		logic alu_and;
		logic alu_or;
		logic alu_xor;
		logic alu_sll;
		logic alu_srl;
		logic alu_sra;
		logic alu_mul;
		logic alu_div;
		logic alu_divu;
	} alu_ctrl_t;

	typedef struct packed {
		logic beq;
		logic bne;
		logic blt;
		logic bge;
		logic bltu;
		logic bgeu;
	} br_ctrl_t;

	typedef struct packed {
		logic load;
		logic store;
		logic mem_h; // halfword access
		logic mem_b; // byte access
		logic mem_u; // zero-extending load
	} mem_ctrl_t;

	typedef struct packed {
		alu_ctrl_t alu;
		br_ctrl_t  br;
		mem_ctrl_t mem;
		logic      jal;
		logic      jalr;
		logic      src1_is_pc;
		logic      src1_unused;
		logic      only_src2_used;
		logic      use_rs2;
		logic      use_imm;
		logic      writes_rd;
		logic      imm_i;
		logic      imm_s;
		logic      imm_b;
		logic      imm_j;
		logic      imm_u;
	} dec_ctrl_t;

	typedef struct packed {
		alu_ctrl_t alu;
		br_ctrl_t  br;
		mem_ctrl_t mem;
		logic      jal;
		logic      jalr;
		logic      only_src2_used;
		data_t     src1;
		data_t     src2;
		data_t     imm;
		data_t     store_data;
		addr_t     pc;
		logic      rd_valid;
		reg_idx_t  rd;
	} ex_pkt_t;

endpackage

//--- hdl/dec_stage.sv
// decode stage top
// fetch packet in, registered ex bundle out one cycle after acceptance
`timescale 1ns/1ns
`include "dec_config.svh"

module dec_stage (
	input                      cpu_clk,
	input                      cpu_rstn,
	input                      if_valid,
	output logic               dec_ready,
	input  dec_pkg::fetch_pkt_t fetch,
	input                      flush,
	input  dec_pkg::fwd_pkt_t  ex_fwd,
	input  dec_pkg::fwd_pkt_t  wb,
	output logic               dec_valid,
	input                      ex_ready,
	output dec_pkg::ex_pkt_t   ex
);

	dec_pkg::dec_ctrl_t ctrl;
	dec_pkg::reg_idx_t  rs1, rs2, rd;
	dec_pkg::data_t     rs1_data, rs2_data;
	dec_pkg::data_t     imm, src1, src2, store_data;
	dec_pkg::ex_pkt_t   ex_in;

	assign rs1 = fetch.instr[`RS1_RANGE];
	assign rs2 = fetch.instr[`RS2_RANGE];
	assign rd  = fetch.instr[`RD_RANGE];

	instr_decoder u_instr_decoder (.instr(fetch.instr), .ctrl(ctrl));

	imm_gen u_imm_gen (.instr(fetch.instr), .ctrl(ctrl), .imm(imm));

	gprs u_gprs (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wb       (wb),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	operand_select u_operand_select (
		.ctrl       (ctrl),
		.rs1        (rs1),
		.rs2        (rs2),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.imm        (imm),
		.pc         (fetch.pc),
		.ex_fwd     (ex_fwd),
		.wb         (wb),
		.src1       (src1),
		.src2       (src2),
		.store_data (store_data)
	);

	assign ex_in = '{
		alu: ctrl.alu, br: ctrl.br, mem: ctrl.mem,
		jal: ctrl.jal, jalr: ctrl.jalr, only_src2_used: ctrl.only_src2_used,
		src1: src1, src2: src2, imm: imm, store_data: store_data,
		pc: fetch.pc, rd_valid: ctrl.writes_rd, rd: rd
	};

	dec_ex_reg u_dec_ex_reg (
		.cpu_clk   (cpu_clk),
		.cpu_rstn  (cpu_rstn),
		.flush     (flush),
		.in_valid  (if_valid),
		.in_ready  (dec_ready),
		.in_pkt    (ex_in),
		.out_valid (dec_valid),
		.out_ready (ex_ready),
		.out_pkt   (ex)
	);

endmodule

//--- hdl/gprs.sv
// 32 entry general purpose register file
// one write port from write-back, two combinational read ports for decode
`timescale 1ns/1ns
`include "dec_config.svh"

module gprs (
	input                      cpu_clk,
	input                      cpu_rstn,
	input  dec_pkg::fwd_pkt_t  wb,
	input  dec_pkg::reg_idx_t  rs1,
	input  dec_pkg::reg_idx_t  rs2,
	output dec_pkg::data_t     rs1_data,
	output dec_pkg::data_t     rs2_data
);

	dec_pkg::data_t regs [`NUM_REGS];
	logic wr_en;

	assign wr_en = wb.valid && (wb.rd != '0); // x0 is never written

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

endmodule

//--- hdl/imm_gen.sv
// immediate assembly for the I, S, B, J and U formats
// format comes from the decoder's one-hot flags
`timescale 1ns/1ns

module imm_gen (
	input  dec_pkg::instr_t    instr,
	input  dec_pkg::dec_ctrl_t ctrl,
	output dec_pkg::data_t     imm
);

	logic sign;

	assign sign = instr[31];

	always_comb
	begin
		if (ctrl.imm_i)
		begin
			imm = {{20{sign}}, instr[31:20]};
		end
		else if (ctrl.imm_s)
		begin
			imm = {{20{sign}}, instr[31:25], instr[11:7]};
		end
		else if (ctrl.imm_b)
		begin
			imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0}; // halfword aligned
		end
		else if (ctrl.imm_j)
		begin
			imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
		end
		else if (ctrl.imm_u)
		begin
			imm = {instr[31:12], 12'b0};
		end
		else
		begin
			imm = '0; // no immediate in this format
		end
	end

endmodule

//--- hdl/instr_decoder.sv
// opcode and funct decoding for RV32IM
// purely combinational, feeds imm_gen, operand_select and the ex bundle
`timescale 1ns/1ns
`include "dec_config.svh"

module instr_decoder (
	input  dec_pkg::instr_t   instr,
	output dec_pkg::dec_ctrl_t ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load, is_store;
	logic is_alu_ir, is_alu_rr;
	logic rr_base; // register ops outside the M extension
	logic rr_md;
	logic alu_any; // immediate or base register form
	logic f7_0, f7_sub;

	assign opcode = instr[`OPCODE_RANGE];
	assign funct3 = instr[`FUNCT3_RANGE];
	assign funct7 = instr[`FUNCT7_RANGE];

	assign is_lui    = (opcode == `LUI);
	assign is_auipc  = (opcode == `AUIPC);
	assign is_jal    = (opcode == `JAL);
	assign is_jalr   = (opcode == `JALR);
	assign is_branch = (opcode == `BRANCH);
	assign is_load   = (opcode == `LOAD);
	assign is_store  = (opcode == `STORE);
	assign is_alu_ir = (opcode == `ALU_IR);
	assign is_alu_rr = (opcode == `ALU_RR);

	assign f7_0    = (funct7 == `FUNCT7_0);
	assign f7_sub  = (funct7 == `FUNCT7_ARITH_SUB);
	assign rr_md   = is_alu_rr & (funct7 == `FUNCT7_MUL_DIV);
	assign rr_base = is_alu_rr & ~rr_md;
	assign alu_any = is_alu_ir | rr_base;

	always_comb
	begin
		ctrl = '0;

		ctrl.alu.use_alu  = is_branch | is_load | is_store | is_alu_ir | is_alu_rr | is_auipc;
		ctrl.alu.alu_add  = is_auipc | is_load | is_store |
			((is_alu_ir | (rr_base & f7_0)) & (funct3 == `FUNCT3_ADD));
		ctrl.alu.alu_sub  = (rr_base & f7_sub & (funct3 == `FUNCT3_ADD)) |
			(is_branch & ((funct3 == `FUNCT3_BEQ) | (funct3 == `FUNCT3_BNE)));
		ctrl.alu.alu_com  = (is_branch & ((funct3 == `FUNCT3_BLT) | (funct3 == `FUNCT3_BGE))) |
			(alu_any & (funct3 == `FUNCT3_SLT));
		ctrl.alu.alu_ucom = (is_branch & ((funct3 == `FUNCT3_BLTU) | (funct3 == `FUNCT3_BGEU))) |
			(alu_any & (funct3 == `FUNCT3_SLTU));
		ctrl.alu.alu_and  = alu_any & (funct3 == `FUNCT3_AND);
		ctrl.alu.alu_or   = alu_any & (funct3 == `FUNCT3_OR);
		ctrl.alu.alu_xor  = alu_any & (funct3 == `FUNCT3_XOR);
		ctrl.alu.alu_sll  = alu_any & (funct3 == `FUNCT3_SLL);
		ctrl.alu.alu_srl  = alu_any & (funct3 == `FUNCT3_SRL) & f7_0;
		ctrl.alu.alu_sra  = alu_any & (funct3 == `FUNCT3_SRL) & f7_sub; // srai shares funct7
		ctrl.alu.alu_mul  = rr_md & (funct3 == `FUNCT3_ADD);
		ctrl.alu.alu_div  = rr_md & (funct3 == `FUNCT3_XOR);
		ctrl.alu.alu_divu = rr_md & (funct3 == `FUNCT3_SRL);

		ctrl.br.beq  = is_branch & (funct3 == `FUNCT3_BEQ);
		ctrl.br.bne  = is_branch & (funct3 == `FUNCT3_BNE);
		ctrl.br.blt  = is_branch & (funct3 == `FUNCT3_BLT);
		ctrl.br.bge  = is_branch & (funct3 == `FUNCT3_BGE);
		ctrl.br.bltu = is_branch & (funct3 == `FUNCT3_BLTU);
		ctrl.br.bgeu = is_branch & (funct3 == `FUNCT3_BGEU);

		// width and sign of the memory access
		ctrl.mem.load  = is_load;
		ctrl.mem.store = is_store;
		ctrl.mem.mem_h = (is_load | is_store) & ((funct3 == `FUNCT3_LSH) | (funct3 == `FUNCT3_LHU));
		ctrl.mem.mem_b = (is_load | is_store) & ((funct3 == `FUNCT3_LSB) | (funct3 == `FUNCT3_LBU));
		ctrl.mem.mem_u = (is_load | is_store) & ((funct3 == `FUNCT3_LHU) | (funct3 == `FUNCT3_LBU));

		ctrl.jal            = is_jal;
		ctrl.jalr           = is_jalr;
		ctrl.src1_is_pc     = is_auipc;
		ctrl.src1_unused    = is_lui | is_jal;
		ctrl.only_src2_used = is_lui | is_jal | is_jalr;

		ctrl.imm_i = is_load | is_alu_ir | is_jalr;
		ctrl.imm_s = is_store;
		ctrl.imm_b = is_branch;
		ctrl.imm_j = is_jal;
		ctrl.imm_u = is_lui | is_auipc;

		ctrl.use_rs2   = is_alu_rr | is_branch;
		ctrl.use_imm   = ctrl.imm_i | ctrl.imm_s | ctrl.imm_u;
		ctrl.writes_rd = is_alu_rr | ctrl.imm_i | ctrl.imm_u | is_jal;
	end

endmodule

//--- hdl/operand_select.sv
// operand resolution for the ex stage
// forwarding order is x0, then ex result, then write-back, then register file
`timescale 1ns/1ns
`include "dec_config.svh"

module operand_select (
	input  dec_pkg::dec_ctrl_t ctrl,
	input  dec_pkg::reg_idx_t  rs1,
	input  dec_pkg::reg_idx_t  rs2,
	input  dec_pkg::data_t     rs1_data,
	input  dec_pkg::data_t     rs2_data,
	input  dec_pkg::data_t     imm,
	input  dec_pkg::addr_t     pc,
	input  dec_pkg::fwd_pkt_t  ex_fwd,
	input  dec_pkg::fwd_pkt_t  wb,
	output dec_pkg::data_t     src1,
	output dec_pkg::data_t     src2,
	output dec_pkg::data_t     store_data
);

	dec_pkg::data_t rs1_res;
	dec_pkg::data_t rs2_res;

	// newest value of one source register
	function automatic dec_pkg::data_t resolve(dec_pkg::reg_idx_t idx, dec_pkg::data_t rf_data,
		dec_pkg::fwd_pkt_t ex_f, dec_pkg::fwd_pkt_t wb_f);
		if (idx == '0)
			return '0;
		else if (ex_f.valid && (ex_f.rd == idx))
			return ex_f.data;
		else if (wb_f.valid && (wb_f.rd == idx))
			return wb_f.data; // written this cycle, not yet in the array
		else
			return rf_data;
	endfunction

	assign rs1_res = resolve(rs1, rs1_data, ex_fwd, wb);
	assign rs2_res = resolve(rs2, rs2_data, ex_fwd, wb);

	always_comb
	begin
		if (ctrl.src1_is_pc)
			src1 = pc; // auipc
		else if (ctrl.src1_unused)
			src1 = '0;
		else
			src1 = rs1_res;
	end

	always_comb
	begin
		if (ctrl.jal || ctrl.jalr)
			src2 = pc + dec_pkg::addr_t'(`PC_STEP); // link address
		else if (ctrl.use_rs2)
			src2 = rs2_res;
		else if (ctrl.use_imm)
			src2 = imm;
		else
			src2 = '0;
	end

	assign store_data = rs2_res;

endmodule

//--- tests/tb_dec_stage.sv
// self-checking testbench for the decode stage
// issues instructions on the fetch side and follows the wb writes in a model array
// every transfer to EX is compared with a packet computed by decode_ref at issue time
`timescale 1ns/1ns
`include "dec_config.svh"

module tb_dec_stage;

	localparam int RESET_CYCLES = 16;
	localparam int N_ALU   = 48;
	localparam int N_MEM   = 36;
	localparam int N_FWD   = 4;
	localparam int N_BP    = 64;
	localparam int N_FLUSH = 2;
	localparam int PLANNED = N_ALU + N_MEM + N_FWD + N_BP + N_FLUSH;
	localparam int TIMEOUT_CYCLES = PLANNED * 20 + RESET_CYCLES;

	logic                cpu_clk = 1'b0;
	logic                cpu_rstn;
	logic                if_valid;
	logic                dec_ready;
	dec_pkg::fetch_pkt_t fetch;
	logic                flush;
	dec_pkg::fwd_pkt_t   ex_fwd;
	dec_pkg::fwd_pkt_t   wb;
	logic                dec_valid;
	logic                ex_ready;
	dec_pkg::ex_pkt_t    ex;

	dec_pkg::data_t   model_regs [`NUM_REGS];
	dec_pkg::ex_pkt_t exp_q [$];
	dec_pkg::ex_pkt_t exp_pkt;
	dec_pkg::ex_pkt_t last_pkt;
	dec_pkg::addr_t   next_pc = 32'h0000_1000;
	logic [31:0]      rng = 32'd89209;
	string            test_name;
	logic             saw_stall = 1'b0;
	int               issued = 0;
	int               flushed = 0;
	int               transfers = 0;
	int               check_count = 0;
	int               value_errors = 0;
	int               other_errors = 0;

	always #4 cpu_clk = ~cpu_clk;

	dec_stage u_dec_stage (
		.cpu_clk   (cpu_clk),
		.cpu_rstn  (cpu_rstn),
		.if_valid  (if_valid),
		.dec_ready (dec_ready),
		.fetch     (fetch),
		.flush     (flush),
		.ex_fwd    (ex_fwd),
		.wb        (wb),
		.dec_valid (dec_valid),
		.ex_ready  (ex_ready),
		.ex        (ex)
	);

	function logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// newest value of a source as seen in the cycle of issue
	function automatic dec_pkg::data_t fwd_value(dec_pkg::reg_idx_t idx,
		dec_pkg::fwd_pkt_t exf, dec_pkg::fwd_pkt_t wbf);
		if (idx == '0)
			return '0;
		if (exf.valid && exf.rd == idx)
			return exf.data;
		if (wbf.valid && wbf.rd == idx)
			return wbf.data;
		return model_regs[idx];
	endfunction

	function automatic dec_pkg::mem_ctrl_t mem_width(logic [2:0] f3);
		dec_pkg::mem_ctrl_t m;
		m = '0;
		case (f3)
			3'b000: m.mem_b = 1'b1;
			3'b001: m.mem_h = 1'b1;
			3'b100:
			begin
				m.mem_b = 1'b1;
				m.mem_u = 1'b1;
			end
			3'b101:
			begin
				m.mem_h = 1'b1;
				m.mem_u = 1'b1;
			end
			default: ; // word access
		endcase
		return m;
	endfunction

	// base integer ops for the legal encodings that get issued
	function automatic dec_pkg::alu_ctrl_t alu_base(logic [2:0] f3, logic [6:0] f7,
		logic imm_form);
		dec_pkg::alu_ctrl_t a;
		a = '0;
		a.use_alu = 1'b1;
		case (f3)
			3'b000:
			begin
				if (!imm_form && f7 == 7'h20)
					a.alu_sub = 1'b1;
				else
					a.alu_add = 1'b1;
			end
			3'b001: a.alu_sll = 1'b1;
			3'b010: a.alu_com = 1'b1;
			3'b011: a.alu_ucom = 1'b1;
			3'b100: a.alu_xor = 1'b1;
			3'b101:
			begin
				if (f7 == 7'h20)
					a.alu_sra = 1'b1;
				else
					a.alu_srl = 1'b1;
			end
			3'b110: a.alu_or = 1'b1;
			default: a.alu_and = 1'b1;
		endcase
		return a;
	endfunction

	function automatic dec_pkg::ex_pkt_t decode_ref(dec_pkg::instr_t ins, dec_pkg::addr_t pc,
		dec_pkg::fwd_pkt_t exf, dec_pkg::fwd_pkt_t wbf);
		dec_pkg::ex_pkt_t p;
		logic [2:0] f3;
		dec_pkg::data_t a, b, imm_i, imm_s, imm_b, imm_j, imm_u;
		f3 = ins[14:12];
		a = fwd_value(ins[19:15], exf, wbf);
		b = fwd_value(ins[24:20], exf, wbf);
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		p = '0;
		p.pc = pc;
		p.rd = ins[11:7];
		p.src1 = a;
		p.store_data = b; // always the resolved rs2
		case (ins[6:0])
			`LUI:
			begin
				p.imm = imm_u;
				p.src1 = '0;
				p.src2 = imm_u;
				p.only_src2_used = 1'b1;
				p.rd_valid = 1'b1;
			end
			`AUIPC:
			begin
				p.imm = imm_u;
				p.src1 = pc;
				p.src2 = imm_u;
				p.alu.use_alu = 1'b1;
				p.alu.alu_add = 1'b1;
				p.rd_valid = 1'b1;
			end
			`JAL:
			begin
				p.imm = imm_j;
				p.src1 = '0;
				p.src2 = pc + `PC_STEP; // link address
				p.jal = 1'b1;
				p.only_src2_used = 1'b1;
				p.rd_valid = 1'b1;
			end
			`JALR:
			begin
				p.imm = imm_i;
				p.src2 = pc + `PC_STEP;
				p.jalr = 1'b1;
				p.only_src2_used = 1'b1;
				p.rd_valid = 1'b1;
			end
			`BRANCH:
			begin
				p.imm = imm_b;
				p.src2 = b;
				p.alu.use_alu = 1'b1;
				case (f3)
					`FUNCT3_BEQ: {p.br.beq, p.alu.alu_sub} = 2'b11;
					`FUNCT3_BNE: {p.br.bne, p.alu.alu_sub} = 2'b11;
					`FUNCT3_BLT: {p.br.blt, p.alu.alu_com} = 2'b11;
					`FUNCT3_BGE: {p.br.bge, p.alu.alu_com} = 2'b11;
					`FUNCT3_BLTU: {p.br.bltu, p.alu.alu_ucom} = 2'b11;
					`FUNCT3_BGEU: {p.br.bgeu, p.alu.alu_ucom} = 2'b11;
					default: ;
				endcase
			end
			`LOAD, `STORE:
			begin
				p.mem = mem_width(f3);
				p.mem.load = (ins[6:0] == `LOAD);
				p.mem.store = (ins[6:0] == `STORE);
				p.imm = p.mem.load ? imm_i : imm_s;
				p.src2 = p.imm; // address offset
				p.alu.use_alu = 1'b1;
				p.alu.alu_add = 1'b1;
				p.rd_valid = p.mem.load;
			end
			`ALU_IR:
			begin
				p.imm = imm_i;
				p.src2 = imm_i;
				p.alu = alu_base(f3, ins[31:25], 1'b1);
				p.rd_valid = 1'b1;
			end
			`ALU_RR:
			begin
				p.src2 = b;
				p.rd_valid = 1'b1;
				if (ins[31:25] == `FUNCT7_MUL_DIV)
				begin
					p.alu.use_alu = 1'b1;
					p.alu.alu_mul = (f3 == 3'b000);
					p.alu.alu_div = (f3 == 3'b100);
					p.alu.alu_divu = (f3 == 3'b101); // other M forms carry no op flag
				end
				else
					p.alu = alu_base(f3, ins[31:25], 1'b0);
			end
			default: ;
		endcase
		return p;
	endfunction

	function dec_pkg::instr_t gen_alu_instr();
		dec_pkg::instr_t ins;
		logic [31:0] r;
		int kind;
		ins = xorshift32();
		r = xorshift32();
		kind = int'(r % 32'd10);
		case (kind)
			0, 1:
			begin
				ins[`OPCODE_RANGE] = `ALU_RR;
				ins[`FUNCT7_RANGE] = ((ins[14:12] == 3'b000 || ins[14:12] == 3'b101) && r[8]) ?
					`FUNCT7_ARITH_SUB : `FUNCT7_0;
			end
			2:
			begin
				ins[`OPCODE_RANGE] = `ALU_RR;
				ins[`FUNCT7_RANGE] = `FUNCT7_MUL_DIV;
			end
			3, 4:
			begin
				ins[`OPCODE_RANGE] = `ALU_IR;
				if (ins[14:12] == 3'b001 || ins[14:12] == 3'b101)
					ins[`FUNCT7_RANGE] = r[8] && ins[14] ? `FUNCT7_ARITH_SUB : `FUNCT7_0;
			end
			5: ins[`OPCODE_RANGE] = `LUI;
			6: ins[`OPCODE_RANGE] = `AUIPC;
			7, 8: ins[`OPCODE_RANGE] = `JAL;
			default:
			begin
				ins[`OPCODE_RANGE] = `JALR;
				ins[`FUNCT3_RANGE] = 3'b000;
			end
		endcase
		return ins;
	endfunction

	function dec_pkg::instr_t gen_mem_instr();
		dec_pkg::instr_t ins;
		logic [31:0] r;
		int m;
		ins = xorshift32();
		r = xorshift32();
		case (r % 32'd3)
			0:
			begin
				m = int'(r[15:8] % 8'd6);
				ins[`OPCODE_RANGE] = `BRANCH;
				ins[`FUNCT3_RANGE] = (m < 2) ? 3'(m) : 3'(m + 2);
			end
			1:
			begin
				m = int'(r[15:8] % 8'd5);
				ins[`OPCODE_RANGE] = `LOAD;
				ins[`FUNCT3_RANGE] = (m < 3) ? 3'(m) : 3'(m + 1);
			end
			default:
			begin
				ins[`OPCODE_RANGE] = `STORE;
				ins[`FUNCT3_RANGE] = 3'(r[15:8] % 8'd3);
			end
		endcase
		return ins;
	endfunction

	function dec_pkg::instr_t rr_add(dec_pkg::reg_idx_t a, dec_pkg::reg_idx_t b);
		return {`FUNCT7_0, b, a, `FUNCT3_ADD, 5'd3, `ALU_RR};
	endfunction

	// holds fetch until the stage takes it
	task send(input dec_pkg::instr_t ins);
		if_valid <= 1'b1;
		fetch <= '{instr: ins, pc: next_pc};
		@(posedge cpu_clk);
		while (!dec_ready)
			@(posedge cpu_clk);
		next_pc = next_pc + `PC_STEP;
		issued++;
	endtask

	task fill_regs();
		for (int i = 1; i < `NUM_REGS; i++)
		begin
			wb <= '{valid: 1'b1, rd: 5'(i), data: xorshift32()};
			@(posedge cpu_clk);
		end
		wb <= '0;
	endtask

	// queue is looked at mid cycle where the checker has settled
	task idle_drain();
		if_valid <= 1'b0;
		ex_fwd <= '0;
		wb <= '0;
		@(negedge cpu_clk);
		while (exp_q.size() != 0)
			@(negedge cpu_clk);
		@(posedge cpu_clk);
	endtask

	// random ex_ready and forwards every cycle that often hit the pending sources
	task stream(input int n);
		int sent;
		logic [31:0] r;
		dec_pkg::instr_t ins;
		sent = 0;
		ins = xorshift32() % 2 ? gen_alu_instr() : gen_mem_instr();
		if_valid <= 1'b1;
		fetch <= '{instr: ins, pc: next_pc};
		while (sent < n)
		begin
			r = xorshift32();
			ex_ready <= (r[1:0] != 2'b00);
			ex_fwd <= '{valid: r[2], rd: r[3] ? ins[`RS1_RANGE] : r[8:4], data: xorshift32()};
			wb <= '{valid: r[9], rd: r[10] ? ins[`RS2_RANGE] : r[15:11], data: xorshift32()};
			@(posedge cpu_clk);
			if (!dec_ready)
				saw_stall = 1'b1;
			else
			begin
				sent++;
				issued++;
				next_pc = next_pc + `PC_STEP;
				ins = xorshift32() % 2 ? gen_alu_instr() : gen_mem_instr();
				fetch <= '{instr: ins, pc: next_pc};
			end
		end
		ex_ready <= 1'b1;
	endtask

	// expected packet at acceptance before the model takes the wb write
	always @(posedge cpu_clk)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
				model_regs[i] = '0;
		end
		else
		begin
			if (if_valid && dec_ready && !flush)
				exp_q.push_back(decode_ref(fetch.instr, fetch.pc, ex_fwd, wb));
			if (wb.valid && wb.rd != '0)
				model_regs[wb.rd] = wb.data;
		end
	end

	always @(posedge cpu_clk)
	begin
		if (cpu_rstn && dec_valid && ex_ready)
		begin
			transfers++;
			last_pkt = ex;
			check_count++;
			assert (exp_q.size() != 0)
			else
			begin
				other_errors++;
				$display("transfer of pc %h arrived with no instruction outstanding", ex.pc);
			end
			if (exp_q.size() != 0)
			begin
				exp_pkt = exp_q.pop_front();
				check_count++;
				assert (ex == exp_pkt)
				else
				begin
					value_errors++;
					$display("ERROR %s: expected %h, actual %h", test_name, exp_pkt, ex);
				end
			end
			if (ex.mem.store || ex.br != '0)
			begin
				check_count++;
				assert (!ex.rd_valid)
				else
				begin
					value_errors++;
					$display("ERROR %s: expected rd_valid 0, actual %b", test_name, ex.rd_valid);
				end
			end
		end
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge cpu_clk);
		$display("run timed out after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		cpu_rstn = 1'b0;
		if_valid = 1'b0;
		fetch = '0;
		flush = 1'b0;
		ex_fwd = '0;
		wb = '0;
		ex_ready = 1'b1;
		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge cpu_clk);
		cpu_rstn <= 1'b1;
		@(posedge cpu_clk);
		check_count++;
		assert (!dec_valid && dec_ready && ex == '0)
		else
		begin
			value_errors++;
			$display("ERROR %s: expected valid 0 ready 1 ex 0, actual valid %b ready %b ex %h",
				test_name, dec_valid, dec_ready, ex);
		end

		test_name = "alu_decode";
		fill_regs();
		repeat (N_ALU) send(gen_alu_instr());
		idle_drain();

		test_name = "branch_load_store";
		fill_regs();
		repeat (N_MEM) send(gen_mem_instr());
		idle_drain();

		// same register hit by both forwards, then EX invalid, then split, then x0
		test_name = "forwarding";
		ex_fwd <= '{valid: 1'b1, rd: 5'd7, data: 32'hEEEE_0007};
		wb <= '{valid: 1'b1, rd: 5'd7, data: 32'hBBBB_0007};
		send(rr_add(5'd7, 5'd7));
		ex_fwd <= '{valid: 1'b0, rd: 5'd7, data: 32'hEEEE_1007};
		wb <= '{valid: 1'b1, rd: 5'd7, data: 32'hBBBB_1007};
		send(rr_add(5'd7, 5'd7));
		ex_fwd <= '{valid: 1'b1, rd: 5'd9, data: 32'hEEEE_0009};
		wb <= '{valid: 1'b1, rd: 5'd10, data: 32'hBBBB_000A};
		send(rr_add(5'd9, 5'd10));
		ex_fwd <= '{valid: 1'b1, rd: 5'd0, data: 32'hEEEE_0000};
		wb <= '{valid: 1'b1, rd: 5'd0, data: 32'hBBBB_0000};
		send(rr_add(5'd0, 5'd0));
		idle_drain();
		check_count++;
		assert (last_pkt.src1 == '0 && last_pkt.src2 == '0)
		else
		begin
			value_errors++;
			$display("ERROR %s: expected x0 operands 0 0, actual %h %h",
				test_name, last_pkt.src1, last_pkt.src2);
		end

		test_name = "back_pressure";
		stream(N_BP);
		idle_drain();
		check_count++;
		assert (saw_stall)
		else
		begin
			other_errors++;
			$display("dec_ready never dropped while EX was stalled");
		end

		test_name = "flush";
		flush <= 1'b1;
		send(gen_alu_instr());
		flushed++;
		flush <= 1'b0;
		send(gen_alu_instr());
		check_count++;
		assert (!dec_valid)
		else
		begin
			value_errors++;
			$display("ERROR %s: expected dec_valid 0, actual %b", test_name, dec_valid);
		end
		idle_drain();

		check_count++;
		assert (transfers == issued - flushed)
		else
		begin
			other_errors++;
			$display("%0d transfers reached EX but %0d instructions were kept",
				transfers, issued - flushed);
		end

		$display("%0d checks, %0d value errors, %0d other errors",
			check_count, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hdl
hdl/dec_pkg.sv
hdl/instr_decoder.sv
hdl/imm_gen.sv
hdl/gprs.sv
hdl/operand_select.sv
hdl/dec_ex_reg.sv
hdl/dec_stage.sv
tests/tb_dec_stage.sv
